/* files.f */
source/cpu_pkg.sv
source/cpu_fetch.sv
source/cpu_fetch_queue.sv
source/cpu_hazard.sv
source/cpu_regfile.sv
source/cpu_pipeline.sv
source/cpu_top.sv
dv/cpu_properties.sv
dv/cpu_tb.sv

/* run.sh */
#!/bin/sh
# builds the core and its testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f files.f -o cpu_sim \
	&& ./obj_dir/cpu_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^=== PASS ===$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* dv/cpu_tb.sv */
/* testbench for cpu_top with a 256-word instruction memory that acks after 0 to 3 wait cycles
   every program must end in an unlinked branch to itself, which the ISA model treats as halt */
`timescale 1ns/1ns

module cpu_tb;

	logic                                clk = 1'b0;
	logic                                rst;
	logic                                ibus_cyc;
	logic                                ibus_stb;
	logic [cpu_pkg::BITS - 1:0]          ibus_adr;
	logic                                ibus_ack = 1'b0;
	logic [cpu_pkg::BITS - 1:0]          ibus_rdata = '0;
	logic                                retire_valid;
	logic [cpu_pkg::REGISTER_BITS - 1:0] retire_reg;
	logic [cpu_pkg::BITS - 1:0]          retire_data;

	logic [15:0] mem [256];
	logic [15:0] prog [$];
	logic [15:0] ref_regs [16];
	logic [3:0]  exp_reg [$];
	logic [15:0] exp_data [$];
	int          exp_index = 0;
	int          compare_errors = 0;
	int          main_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	string       test_name = "reset";

	cpu_top UUT (
		.clk         (clk),
		.rst         (rst),
		.ibus_cyc    (ibus_cyc),
		.ibus_stb    (ibus_stb),
		.ibus_adr    (ibus_adr),
		.ibus_ack    (ibus_ack),
		.ibus_rdata  (ibus_rdata),
		.retire_valid(retire_valid),
		.retire_reg  (retire_reg),
		.retire_data (retire_data)
	);

	always #10 clk = ~clk;

	// slave side of the fetch bus, a fresh random wait for every request
	always @(posedge clk) begin
		static bit active = 1'b0;
		static int ack_wait = 0;
		#1;
		if (ibus_ack || !ibus_cyc) begin
			ibus_ack = 1'b0;
			active = 1'b0;
		end else if (ibus_stb) begin
			if (!active) begin
				active = 1'b1;
				ack_wait = $urandom_range(3, 0);
			end
			if (ack_wait == 0) begin
				ibus_ack = 1'b1;
				ibus_rdata = mem[ibus_adr[7:0]];
			end else begin
				ack_wait--;
			end
		end
	end

	// retire outputs come straight from flops, so mid-cycle they are settled
	always @(negedge clk) begin
		if (rst) begin
			exp_index = 0;
		end else if (retire_valid) begin
			assert (exp_index < exp_reg.size())
			else begin
				$display("test %s: unexpected write to r%0d at %0t after all %0d expected writes",
					test_name, retire_reg, $time, exp_reg.size());
				compare_errors++;
			end
			if (exp_index < exp_reg.size()) begin
				assert (retire_reg == exp_reg[exp_index] && retire_data == exp_data[exp_index])
				else begin
					$display("error %0t: test %s write %0d is r%0d = %h, expected r%0d = %h",
						$time, test_name, exp_index, retire_reg, retire_data,
						exp_reg[exp_index], exp_data[exp_index]);
					compare_errors++;
				end
			end
			exp_index++;
		end
	end

	function automatic logic [15:0] alu_word(input cpu_pkg::opcode_t op, input logic [3:0] rd,
		input logic [3:0] ra, input logic [3:0] rb);
		return {op, rd, ra, rb};
	endfunction

	function automatic logic [15:0] load_imm(input logic [3:0] rd, input logic [7:0] imm);
		return {cpu_pkg::op_ldi, rd, imm};
	endfunction

	function automatic logic [15:0] single_word(input cpu_pkg::single_op_t sop,
		input logic [3:0] rd);
		return {cpu_pkg::op_single, rd, 4'h0, sop};
	endfunction

	function automatic logic [15:0] branch_word(input cpu_pkg::branch_cond_t cond,
		input logic link, input int offset);
		return {cpu_pkg::op_br, cond, link, 9'(offset)};
	endfunction

	// ISA semantics of the flag-setting ops, d is the old value of rd
	function automatic logic [15:0] alu_result(input logic [15:0] ins, input logic [15:0] a,
		input logic [15:0] b, input logic [15:0] d);
		case (cpu_pkg::opcode_from_ins(ins))
			cpu_pkg::op_add:  return a + b;
			cpu_pkg::op_sub:  return a - b;
			cpu_pkg::op_and:  return a & b;
			cpu_pkg::op_or:   return a | b;
			cpu_pkg::op_xor:  return a ^ b;
			cpu_pkg::op_addi: return a + {12'h000, ins[3:0]};
			cpu_pkg::op_ldi:  return {8'h00, ins[7:0]};
			default: begin
				case (ins[3:0])
					4'h0: return d + 16'd1;
					4'h1: return d - 16'd1;
					4'h2: return ~d;
					4'h3: return {1'b0, d[15:1]};
					default: return d;
				endcase
			end
		endcase
	endfunction

	function automatic void record_write(input logic [3:0] rd, input logic [15:0] value);
		if (rd != 4'd0) begin
			ref_regs[rd] = value;
			exp_reg.push_back(rd);
			exp_data.push_back(value);
		end
	endfunction

	// runs the program in mem until the halt and returns 0 if it never gets there
	function automatic bit run_reference();
		logic [15:0] pc;
		logic [15:0] next_pc;
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		logic [3:0]  rd;
		logic        z;
		logic        taken;
		pc = '0;
		z = 1'b0;
		foreach (ref_regs[i])
			ref_regs[i] = '0;
		exp_reg.delete();
		exp_data.delete();
		for (int step = 0; step < 1000; step++) begin
			ins = mem[pc[7:0]];
			rd = cpu_pkg::reg_dest_from_ins(ins);
			a = ref_regs[cpu_pkg::reg_a_from_ins(ins)];
			b = ref_regs[cpu_pkg::reg_b_from_ins(ins)];
			next_pc = pc + 16'd1;
			case (cpu_pkg::opcode_from_ins(ins))
				cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
				cpu_pkg::op_xor, cpu_pkg::op_addi, cpu_pkg::op_ldi, cpu_pkg::op_single: begin
					r = alu_result(ins, a, b, ref_regs[rd]);
					z = r == 16'd0;
					record_write(rd, r);
				end
				cpu_pkg::op_movz: begin
					if (z)
						record_write(rd, a);
				end
				cpu_pkg::op_br: begin
					case (cpu_pkg::branch_cond_from_ins(ins))
						cpu_pkg::br_always:  taken = 1'b1;
						cpu_pkg::br_z_set:   taken = z;
						cpu_pkg::br_z_clear: taken = !z;
						default:             taken = 1'b0;
					endcase
					if (taken && ins[8:0] == 9'd0 && !cpu_pkg::is_branch_link_from_ins(ins))
						return 1'b1;
					if (taken && cpu_pkg::is_branch_link_from_ins(ins))
						record_write(cpu_pkg::LINK_REGISTER, pc + 16'd1);
					if (taken)
						next_pc = pc + cpu_pkg::branch_offset_from_ins(ins);
				end
				default: ;
			endcase
			pc = next_pc;
		end
		return 1'b0;
	endfunction

	task automatic run_program(input string name);
		int cycles;
		int errors_before;
		errors_before = compare_errors + main_errors;
		@(posedge clk);
		#1;
		rst = 1'b1;
		test_name = name;
		// unused words decode as no-ops tagged with their address
		for (int i = 0; i < 256; i++)
			mem[i] = {4'hA, 4'h0, 8'(i)};
		foreach (prog[i])
			mem[i] = prog[i];
		if (!run_reference()) begin
			$display("test %s: the ISA model did not reach a halt", name);
			main_errors++;
		end
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		cycles = 0;
		while (exp_index < exp_reg.size() && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_index < exp_reg.size()) begin
			$display("test %s: timed out with only %0d of %0d expected writes retired",
				name, exp_index, exp_reg.size());
			main_errors++;
		end
		// the halt loop must stay silent
		repeat (20) @(posedge clk);
		tests_run++;
		if (compare_errors + main_errors != errors_before)
			tests_failed++;
		$display("test %-10s %s, %0d writes expected", name,
			(compare_errors + main_errors == errors_before) ? "ok" : "failed", exp_reg.size());
		prog.delete();
	endtask

	task automatic make_random_program();
		int          kind;
		logic [3:0]  rd;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [15:0] word;
		for (int i = 0; i < 30; i++) begin
			kind = $urandom_range(15, 0);
			rd = 4'($urandom_range(15, 0));
			ra = 4'($urandom_range(15, 0));
			rb = 4'($urandom_range(15, 0));
			case (kind)
				5: word = alu_word(cpu_pkg::op_addi, rd, ra, rb);
				6: word = load_imm(rd, 8'($urandom));
				7, 8: word = single_word(cpu_pkg::single_op_t'({2'b00, rb[1:0]}), rd);
				9: word = alu_word(cpu_pkg::op_movz, rd, ra, 4'h0);
				10, 11: word = branch_word(cpu_pkg::branch_cond_t'(2'($urandom_range(2, 0))),
					rb[0], $urandom_range(30 - i, 1));
				default: word = alu_word(cpu_pkg::opcode_t'(4'(kind % 5)), rd, ra, rb);
			endcase
			prog.push_back(word);
		end
		prog.push_back(branch_word(cpu_pkg::br_always, 1'b0, 0));
	endtask

	initial begin
		rst = 1'b1;
		void'($urandom(32'h55d9));

		prog = '{load_imm(4'd1, 8'h12), load_imm(4'd2, 8'h34), load_imm(4'd3, 8'hf0),
			load_imm(4'd4, 8'h0f), alu_word(cpu_pkg::op_add, 4'd5, 4'd1, 4'd2),
			alu_word(cpu_pkg::op_sub, 4'd6, 4'd1, 4'd2), alu_word(cpu_pkg::op_and, 4'd7, 4'd3, 4'd4),
			alu_word(cpu_pkg::op_or, 4'd8, 4'd3, 4'd4), alu_word(cpu_pkg::op_xor, 4'd9, 4'd1, 4'd3),
			alu_word(cpu_pkg::op_addi, 4'd10, 4'd2, 4'd9), single_word(cpu_pkg::sop_inc, 4'd1),
			single_word(cpu_pkg::sop_dec, 4'd2), single_word(cpu_pkg::sop_not, 4'd3),
			single_word(cpu_pkg::sop_shr, 4'd4), branch_word(cpu_pkg::br_always, 1'b0, 0)};
		run_program("alu");

		// sources A and B at distance 1, then distances 2 and 3
		prog = '{load_imm(4'd1, 8'h05), alu_word(cpu_pkg::op_add, 4'd2, 4'd1, 4'd0),
			alu_word(cpu_pkg::op_add, 4'd3, 4'd0, 4'd2), load_imm(4'd4, 8'h03),
			load_imm(4'd5, 8'h07), alu_word(cpu_pkg::op_sub, 4'd6, 4'd4, 4'd0),
			load_imm(4'd7, 8'h09), load_imm(4'd8, 8'h02), load_imm(4'd9, 8'h01),
			alu_word(cpu_pkg::op_xor, 4'd10, 4'd0, 4'd7), single_word(cpu_pkg::sop_inc, 4'd10),
			single_word(cpu_pkg::sop_shr, 4'd10), alu_word(cpu_pkg::op_and, 4'd11, 4'd10, 4'd6),
			branch_word(cpu_pkg::br_always, 1'b0, 0)};
		run_program("depend");

		prog = '{load_imm(4'd1, 8'h01), single_word(cpu_pkg::sop_dec, 4'd1),
			branch_word(cpu_pkg::br_z_set, 1'b0, 2), load_imm(4'd2, 8'h11),
			load_imm(4'd5, 8'h05), branch_word(cpu_pkg::br_z_set, 1'b0, 2),
			load_imm(4'd6, 8'h66), alu_word(cpu_pkg::op_or, 4'd7, 4'd0, 4'd0),
			branch_word(cpu_pkg::br_z_clear, 1'b0, 2), load_imm(4'd8, 8'h88),
			branch_word(cpu_pkg::br_z_clear, 1'b0, 2), load_imm(4'd9, 8'h99),
			alu_word(cpu_pkg::op_and, 4'd10, 4'd0, 4'd5), alu_word(cpu_pkg::op_movz, 4'd11, 4'd5, 4'd0),
			single_word(cpu_pkg::sop_inc, 4'd10), alu_word(cpu_pkg::op_movz, 4'd12, 4'd5, 4'd0),
			branch_word(cpu_pkg::br_always, 1'b0, 0)};
		run_program("flags");

		prog = '{load_imm(4'd1, 8'h21), branch_word(cpu_pkg::br_always, 1'b1, 3),
			load_imm(4'd2, 8'haa), load_imm(4'd3, 8'hbb), alu_word(cpu_pkg::op_add, 4'd4, 4'd15, 4'd0),
			alu_word(cpu_pkg::op_addi, 4'd5, 4'd15, 4'd1), branch_word(cpu_pkg::br_always, 1'b0, 0)};
		run_program("link");

		prog = '{load_imm(4'd1, 8'h3c), load_imm(4'd0, 8'h55),
			alu_word(cpu_pkg::op_add, 4'd0, 4'd1, 4'd1), alu_word(cpu_pkg::op_add, 4'd2, 4'd0, 4'd0),
			single_word(cpu_pkg::sop_inc, 4'd0), alu_word(cpu_pkg::op_addi, 4'd3, 4'd0, 4'd7),
			alu_word(cpu_pkg::op_or, 4'd4, 4'd1, 4'd0), branch_word(cpu_pkg::br_always, 1'b0, 0)};
		run_program("r0");

		for (int n = 0; n < 10; n++) begin
			make_random_program();
			run_program($sformatf("random%0d", n));
		end

		$display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, compare_errors + main_errors, UUT.u_properties.failures);
		if (compare_errors + main_errors == 0 && UUT.u_properties.failures == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* dv/cpu_properties.sv */
/* Wishbone classic rules for the instruction bus and a retire port check, bound into cpu_top
   failures holds the number of failed properties over the whole run */
`timescale 1ns/1ns

module cpu_properties (
	input logic                                clk,
	input logic                                rst,
	input logic                                ibus_cyc,
	input logic                                ibus_stb,
	input logic [cpu_pkg::BITS - 1:0]          ibus_adr,
	input logic                                ibus_ack,
	input logic                                retire_valid,
	input logic [cpu_pkg::REGISTER_BITS - 1:0] retire_reg
);

	int failures = 0;

	stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) ibus_stb |-> ibus_cyc)
		else begin
			$error("ibus_stb is high while ibus_cyc is low");
			failures++;
		end

	// a request holds its address until the slave acknowledges it
	adr_held: assert property (@(posedge clk) disable iff (rst)
		ibus_stb && !ibus_ack |=> ibus_stb && $stable(ibus_adr))
		else begin
			$error("ibus request dropped or address changed before ack");
			failures++;
		end

	idle_after_ack: assert property (@(posedge clk) disable iff (rst)
		ibus_cyc && ibus_ack |=> !ibus_cyc)
		else begin
			$error("ibus_cyc still high in the cycle after ack");
			failures++;
		end

	no_r0_retire: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> retire_reg != cpu_pkg::R0)
		else begin
			$error("retire port shows a write to r0");
			failures++;
		end

	// cyc is registered, so it clears one cycle into reset
	quiet_in_reset: assert property (@(posedge clk) rst |=> !ibus_cyc)
		else begin
			$error("ibus_cyc is high during reset");
			failures++;
		end

endmodule

bind cpu_top cpu_properties u_properties (
	.clk         (clk),
	.rst         (rst),
	.ibus_cyc    (ibus_cyc),
	.ibus_stb    (ibus_stb),
	.ibus_adr    (ibus_adr),
	.ibus_ack    (ibus_ack),
	.retire_valid(retire_valid),
	.retire_reg  (retire_reg)
);

/* source/cpu_top.sv */
/* core top level, instruction fetch over Wishbone classic with word addresses
   there is no data bus, retires are visible only on the retire port */
`timescale 1ns/1ns

module cpu_top (
	input  logic                                clk,
	input  logic                                rst,
	output logic                                ibus_cyc,
	output logic                                ibus_stb,
	output logic [cpu_pkg::BITS - 1:0]          ibus_adr,
	input  logic                                ibus_ack,
	input  logic [cpu_pkg::BITS - 1:0]          ibus_rdata,
	output logic                                retire_valid,
	output logic [cpu_pkg::REGISTER_BITS - 1:0] retire_reg,
	output logic [cpu_pkg::BITS - 1:0]          retire_data
);

	logic                       redirect;
	logic [cpu_pkg::BITS - 1:0] redirect_pc;
	logic                       f_valid;
	logic [cpu_pkg::BITS - 1:0] f_word;
	logic [cpu_pkg::BITS - 1:0] f_pc;
	logic                       q_valid;
	logic [cpu_pkg::BITS - 1:0] q_word;
	logic [cpu_pkg::BITS - 1:0] q_pc;
	logic [1:0]                 q_count;
	logic                       q_take;

	cpu_fetch u_fetch (
		.clk        (clk),
		.rst        (rst),
		.ibus_cyc   (ibus_cyc),
		.ibus_stb   (ibus_stb),
		.ibus_adr   (ibus_adr),
		.ibus_ack   (ibus_ack),
		.ibus_rdata (ibus_rdata),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.q_count    (q_count),
		.f_valid    (f_valid),
		.f_word     (f_word),
		.f_pc       (f_pc)
	);

	// a taken branch flushes the queue in its own cycle
	cpu_fetch_queue u_queue (
		.clk    (clk),
		.rst    (rst),
		.f_valid(f_valid),
		.f_word (f_word),
		.f_pc   (f_pc),
		.q_take (q_take),
		.flush  (redirect),
		.q_valid(q_valid),
		.q_word (q_word),
		.q_pc   (q_pc),
		.q_count(q_count)
	);

	cpu_pipeline u_pipeline (
		.clk         (clk),
		.rst         (rst),
		.q_valid     (q_valid),
		.q_word      (q_word),
		.q_pc        (q_pc),
		.q_take      (q_take),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.retire_valid(retire_valid),
		.retire_reg  (retire_reg),
		.retire_data (retire_data)
	);

endmodule

/* source/cpu_pipeline.sv */
/* four-slot in-order pipeline, issue and branch resolve in p0, writeback in p3
   results are computed on issue, dependants stall until the producer has left p3 */
`timescale 1ns/1ns

module cpu_pipeline (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                q_valid,
	input  logic [cpu_pkg::BITS - 1:0]          q_word,
	input  logic [cpu_pkg::BITS - 1:0]          q_pc,
	output logic                                q_take,
	output logic                                redirect,
	output logic [cpu_pkg::BITS - 1:0]          redirect_pc,
	output logic                                retire_valid,
	output logic [cpu_pkg::REGISTER_BITS - 1:0] retire_reg,
	output logic [cpu_pkg::BITS - 1:0]          retire_data
);

	cpu_pkg::opcode_t                    op;
	logic [cpu_pkg::REGISTER_BITS - 1:0] rsel_a;
	logic [cpu_pkg::REGISTER_BITS - 1:0] rsel_b;
	logic [cpu_pkg::BITS - 1:0]          a;
	logic [cpu_pkg::BITS - 1:0]          b;
	logic [cpu_pkg::REGISTER_BITS - 1:0] hazard_reg0;
	logic                                modifies_flags0;
	logic                                hazard_1;
	logic                                hazard_2;
	logic                                hazard_3;
	logic                                issue;
	logic                                taken;
	logic [cpu_pkg::REGISTER_BITS - 1:0] wr_dest;
	logic [cpu_pkg::BITS - 1:0]          result;
	logic                                z_flag;

	// slots 1 to 3
	logic                                valid [1:3];
	logic [cpu_pkg::REGISTER_BITS - 1:0] dest [1:3];
	logic                                mflags [1:3];
	logic [cpu_pkg::BITS - 1:0]          res [1:3];
	logic                                z [1:3];
	logic                                cond [1:3];

	assign op     = cpu_pkg::opcode_from_ins(q_word);
	assign rsel_a = cpu_pkg::src_a_sel(q_word);
	assign rsel_b = cpu_pkg::src_b_sel(q_word);

	cpu_hazard u_hazard (
		.instruction    (q_word),
		.rega_sel0      (rsel_a),
		.regb_sel0      (rsel_b),
		.hazard_reg0    (hazard_reg0),
		.modifies_flags0(modifies_flags0),
		.hazard_reg1    (dest[1]),
		.hazard_reg2    (dest[2]),
		.hazard_reg3    (dest[3]),
		.modifies_flags1(mflags[1]),
		.modifies_flags2(mflags[2]),
		.modifies_flags3(mflags[3]),
		.hazard_1       (hazard_1),
		.hazard_2       (hazard_2),
		.hazard_3       (hazard_3)
	);

	cpu_regfile u_regfile (
		.clk    (clk),
		.rst    (rst),
		.rsel_a (rsel_a),
		.rsel_b (rsel_b),
		.rdata_a(a),
		.rdata_b(b),
		.we     (retire_valid),
		.wsel   (retire_reg),
		.wdata  (retire_data)
	);

	assign issue  = q_valid && !(hazard_1 || hazard_2 || hazard_3);
	assign q_take = issue;

	always_comb begin
		taken = 1'b0;
		if (op == cpu_pkg::op_br) begin
			case (cpu_pkg::branch_cond_from_ins(q_word))
				cpu_pkg::br_always:  taken = 1'b1;
				cpu_pkg::br_z_set:   taken = z_flag;
				cpu_pkg::br_z_clear: taken = !z_flag;
				default: ;
			endcase
		end
	end

	assign redirect    = issue && taken;
	assign redirect_pc = q_pc + cpu_pkg::branch_offset_from_ins(q_word);

	// a branch that falls through does not link
	assign wr_dest = (op == cpu_pkg::op_br && !taken) ? cpu_pkg::R0 : hazard_reg0;

	always_comb begin
		case (op)
			cpu_pkg::op_add:  result = a + b;
			cpu_pkg::op_sub:  result = a - b;
			cpu_pkg::op_and:  result = a & b;
			cpu_pkg::op_or:   result = a | b;
			cpu_pkg::op_xor:  result = a ^ b;
			cpu_pkg::op_addi: result = a + cpu_pkg::imm4_from_ins(q_word);
			cpu_pkg::op_ldi:  result = cpu_pkg::imm8_from_ins(q_word);
			cpu_pkg::op_single: begin
				case (cpu_pkg::single_op_from_ins(q_word))
					cpu_pkg::sop_inc: result = a + 1'b1;
					cpu_pkg::sop_dec: result = a - 1'b1;
					cpu_pkg::sop_not: result = ~a;
					cpu_pkg::sop_shr: result = a >> 1;
					default:          result = a;
				endcase
			end
			cpu_pkg::op_movz: result = a;
			cpu_pkg::op_br:   result = q_pc + 1'b1;
			default:          result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i <= 3; i++) begin
				valid[i]  <= 1'b0;
				dest[i]   <= cpu_pkg::R0;
				mflags[i] <= 1'b0;
			end
		end else begin
			// stalls and non-linking branches put a bubble into p1
			valid[1]  <= issue && !(op == cpu_pkg::op_br && wr_dest == cpu_pkg::R0);
			dest[1]   <= issue ? wr_dest : cpu_pkg::R0;
			mflags[1] <= issue && modifies_flags0;
			for (int i = 2; i <= 3; i++) begin
				valid[i]  <= valid[i - 1];
				dest[i]   <= dest[i - 1];
				mflags[i] <= mflags[i - 1];
			end
		end
	end

	always_ff @(posedge clk) begin
		res[1]  <= result;
		z[1]    <= result == '0;
		cond[1] <= op == cpu_pkg::op_movz;
		for (int i = 2; i <= 3; i++) begin
			res[i]  <= res[i - 1];
			z[i]    <= z[i - 1];
			cond[i] <= cond[i - 1];
		end
	end

	// movz sees Z as committed by every older instruction
	assign retire_valid = valid[3] && dest[3] != cpu_pkg::R0 && (!cond[3] || z_flag);
	assign retire_reg   = dest[3];
	assign retire_data  = res[3];

	always_ff @(posedge clk) begin
		if (rst)
			z_flag <= 1'b0;
		else if (valid[3] && mflags[3])
			z_flag <= z[3];
	end

endmodule

/* source/cpu_regfile.sv */
/* 16 x 16 register file, two combinational reads and one write at the clock edge
   R0 reads as zero and ignores writes, a read in the write cycle returns the old value */
`timescale 1ns/1ns

module cpu_regfile (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [cpu_pkg::REGISTER_BITS - 1:0] rsel_a,
	input  logic [cpu_pkg::REGISTER_BITS - 1:0] rsel_b,
	output logic [cpu_pkg::BITS - 1:0]          rdata_a,
	output logic [cpu_pkg::BITS - 1:0]          rdata_b,
	input  logic                                we,
	input  logic [cpu_pkg::REGISTER_BITS - 1:0] wsel,
	input  logic [cpu_pkg::BITS - 1:0]          wdata
);

	logic [cpu_pkg::BITS - 1:0] regs [1 << cpu_pkg::REGISTER_BITS];

	assign rdata_a = (rsel_a == cpu_pkg::R0) ? '0 : regs[rsel_a];
	assign rdata_b = (rsel_b == cpu_pkg::R0) ? '0 : regs[rsel_b];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < (1 << cpu_pkg::REGISTER_BITS); i++)
				regs[i] <= '0;
		end else if (we && wsel != cpu_pkg::R0) begin
			regs[wsel] <= wdata;
		end
	end

endmodule

/* source/cpu_hazard.sv */
/* hazard detection for the p0 instruction against slots 1 to 3, purely combinational
   there is no forwarding, so any match means p0 waits */
`timescale 1ns/1ns

module cpu_hazard (
	input  logic [cpu_pkg::BITS - 1:0]          instruction,
	input  logic [cpu_pkg::REGISTER_BITS - 1:0] rega_sel0,
	input  logic [cpu_pkg::REGISTER_BITS - 1:0] regb_sel0,
	output logic [cpu_pkg::REGISTER_BITS - 1:0] hazard_reg0,
	output logic                                modifies_flags0,
	input  logic [cpu_pkg::REGISTER_BITS - 1:0] hazard_reg1,
	input  logic [cpu_pkg::REGISTER_BITS - 1:0] hazard_reg2,
	input  logic [cpu_pkg::REGISTER_BITS - 1:0] hazard_reg3,
	input  logic                                modifies_flags1,
	input  logic                                modifies_flags2,
	input  logic                                modifies_flags3,
	output logic                                hazard_1,
	output logic                                hazard_2,
	output logic                                hazard_3
);

	cpu_pkg::opcode_t op;
	logic             flag_branch;

	assign op          = cpu_pkg::opcode_from_ins(instruction);
	assign flag_branch = op == cpu_pkg::op_br && cpu_pkg::uses_flags_for_branch(instruction);

	// destination and flag effect that travel with the instruction
	always_comb begin
		hazard_reg0     = cpu_pkg::R0;
		modifies_flags0 = 1'b0;
		case (op)
			cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
			cpu_pkg::op_xor, cpu_pkg::op_addi, cpu_pkg::op_ldi, cpu_pkg::op_single: begin
				hazard_reg0     = cpu_pkg::reg_dest_from_ins(instruction);
				modifies_flags0 = 1'b1;
			end
			cpu_pkg::op_movz: begin
				hazard_reg0 = cpu_pkg::reg_dest_from_ins(instruction);
			end
			cpu_pkg::op_br: begin
				if (cpu_pkg::is_branch_link_from_ins(instruction))
					hazard_reg0 = cpu_pkg::LINK_REGISTER;
			end
			default: ;
		endcase
	end

	always_comb begin
		hazard_1 = 1'b0;
		hazard_2 = 1'b0;
		hazard_3 = 1'b0;

		if (rega_sel0 != cpu_pkg::R0) begin
			hazard_1 = hazard_1 | (rega_sel0 == hazard_reg1);
			hazard_2 = hazard_2 | (rega_sel0 == hazard_reg2);
			hazard_3 = hazard_3 | (rega_sel0 == hazard_reg3);
		end

		if (regb_sel0 != cpu_pkg::R0) begin
			hazard_1 = hazard_1 | (regb_sel0 == hazard_reg1);
			hazard_2 = hazard_2 | (regb_sel0 == hazard_reg2);
			hazard_3 = hazard_3 | (regb_sel0 == hazard_reg3);
		end

		// conditional branches read Z, which commits only when a producer retires
		if (flag_branch) begin
			hazard_1 = hazard_1 | modifies_flags1;
			hazard_2 = hazard_2 | modifies_flags2;
			hazard_3 = hazard_3 | modifies_flags3;
		end
	end

endmodule

/* source/cpu_fetch_queue.sv */
/* two-entry FIFO of instruction word and pc, push and pop may share a cycle
   flush drops the contents and any push in that cycle, pushes into a full queue are not checked */
`timescale 1ns/1ns

module cpu_fetch_queue (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       f_valid,
	input  logic [cpu_pkg::BITS - 1:0] f_word,
	input  logic [cpu_pkg::BITS - 1:0] f_pc,
	input  logic                       q_take,
	input  logic                       flush,
	output logic                       q_valid,
	output logic [cpu_pkg::BITS - 1:0] q_word,
	output logic [cpu_pkg::BITS - 1:0] q_pc,
	output logic [1:0]                 q_count
);

	logic [cpu_pkg::BITS - 1:0] word_mem [2];
	logic [cpu_pkg::BITS - 1:0] pc_mem [2];
	logic                       wr_ptr;
	logic                       rd_ptr;
	logic                       push;

	assign push    = f_valid && !flush;
	assign q_valid = q_count != 2'd0;
	assign q_word  = word_mem[rd_ptr];
	assign q_pc    = pc_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wr_ptr  <= 1'b0;
			rd_ptr  <= 1'b0;
			q_count <= 2'd0;
		end else begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (q_take)
				rd_ptr <= ~rd_ptr;
			case ({push, q_take})
				2'b10: q_count <= q_count + 2'd1;
				2'b01: q_count <= q_count - 2'd1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			word_mem[wr_ptr] <= f_word;
			pc_mem[wr_ptr]   <= f_pc;
		end
	end

endmodule

/* source/cpu_fetch.sv */
/* Wishbone classic instruction master, one transaction at a time
   it only starts a cycle when the queue can hold the word, so queue writes never overflow */
`timescale 1ns/1ns

module cpu_fetch (
	input  logic                       clk,
	input  logic                       rst,
	output logic                       ibus_cyc,
	output logic                       ibus_stb,
	output logic [cpu_pkg::BITS - 1:0] ibus_adr,
	input  logic                       ibus_ack,
	input  logic [cpu_pkg::BITS - 1:0] ibus_rdata,
	input  logic                       redirect,
	input  logic [cpu_pkg::BITS - 1:0] redirect_pc,
	input  logic [1:0]                 q_count,
	output logic                       f_valid,
	output logic [cpu_pkg::BITS - 1:0] f_word,
	output logic [cpu_pkg::BITS - 1:0] f_pc
);

	logic                       busy;
	logic                       discard;
	logic                       room;
	logic [cpu_pkg::BITS - 1:0] pc;

	// a word presented this cycle is not yet counted by the queue
	assign room = ({1'b0, q_count} + {2'b00, f_valid}) < 3'd2;

	assign ibus_cyc = busy;
	assign ibus_stb = busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			discard  <= 1'b0;
			pc       <= '0;
			ibus_adr <= '0;
			f_valid  <= 1'b0;
		end else begin
			f_valid <= 1'b0;
			if (busy) begin
				if (ibus_ack) begin
					busy    <= 1'b0;
					discard <= 1'b0;
					// stale words from before a redirect are dropped here
					if (!discard && !redirect) begin
						f_valid <= 1'b1;
						pc      <= pc + 1'b1;
					end
				end else if (redirect) begin
					discard <= 1'b1;
				end
			end else if (!redirect && room) begin
				busy     <= 1'b1;
				ibus_adr <= pc;
			end
			// the new target wins over any increment in the same cycle
			if (redirect)
				pc <= redirect_pc;
		end
	end

	// the pc of the word is the address still held on the bus
	always_ff @(posedge clk) begin
		if (busy && ibus_ack) begin
			f_word <= ibus_rdata;
			f_pc   <= ibus_adr;
		end
	end

endmodule

/* source/cpu_pkg.sv */
/* opcodes 10 to 15 and branch condition 3 are unassigned and behave as no-ops
   addi and ldi immediates are zero extended, branch offsets are signed words */
package cpu_pkg;

	localparam int BITS = 16;
	localparam int REGISTER_BITS = 4;
	localparam int OFFSET_BITS = 9;
	localparam logic [REGISTER_BITS - 1:0] R0 = 4'd0;
	localparam logic [REGISTER_BITS - 1:0] LINK_REGISTER = 4'd15;

	typedef enum logic [3:0] {
		op_add    = 4'h0,
		op_sub    = 4'h1,
		op_and    = 4'h2,
		op_or     = 4'h3,
		op_xor    = 4'h4,
		op_addi   = 4'h5,
		op_ldi    = 4'h6,
		op_single = 4'h7,
		op_movz   = 4'h8,
		op_br     = 4'h9
	} opcode_t;

	// subop of op_single, held in the rb field
	typedef enum logic [3:0] {
		sop_inc = 4'h0,
		sop_dec = 4'h1,
		sop_not = 4'h2,
		sop_shr = 4'h3
	} single_op_t;

	// branch word is cond[11:10], link[9], offset[8:0]
	typedef enum logic [1:0] {
		br_always  = 2'd0,
		br_z_set   = 2'd1,
		br_z_clear = 2'd2
	} branch_cond_t;

	function automatic opcode_t opcode_from_ins(input logic [BITS - 1:0] ins);
		return opcode_t'(ins[15:12]);
	endfunction

	function automatic logic [REGISTER_BITS - 1:0] reg_dest_from_ins(input logic [BITS - 1:0] ins);
		return ins[11:8];
	endfunction

	function automatic logic [REGISTER_BITS - 1:0] reg_a_from_ins(input logic [BITS - 1:0] ins);
		return ins[7:4];
	endfunction

	function automatic logic [REGISTER_BITS - 1:0] reg_b_from_ins(input logic [BITS - 1:0] ins);
		return ins[3:0];
	endfunction

	function automatic logic [BITS - 1:0] imm4_from_ins(input logic [BITS - 1:0] ins);
		return BITS'(ins[3:0]);
	endfunction

	function automatic logic [BITS - 1:0] imm8_from_ins(input logic [BITS - 1:0] ins);
		return BITS'(ins[7:0]);
	endfunction

	function automatic single_op_t single_op_from_ins(input logic [BITS - 1:0] ins);
		return single_op_t'(ins[3:0]);
	endfunction

	// single-register ops read their destination on port a
	function automatic logic [REGISTER_BITS - 1:0] src_a_sel(input logic [BITS - 1:0] ins);
		case (opcode_from_ins(ins))
			op_add, op_sub, op_and, op_or, op_xor, op_addi, op_movz: return reg_a_from_ins(ins);
			op_single: return reg_dest_from_ins(ins);
			default: return R0;
		endcase
	endfunction

	function automatic logic [REGISTER_BITS - 1:0] src_b_sel(input logic [BITS - 1:0] ins);
		case (opcode_from_ins(ins))
			op_add, op_sub, op_and, op_or, op_xor: return reg_b_from_ins(ins);
			default: return R0;
		endcase
	endfunction

	function automatic branch_cond_t branch_cond_from_ins(input logic [BITS - 1:0] ins);
		return branch_cond_t'(ins[11:10]);
	endfunction

	function automatic logic is_branch_link_from_ins(input logic [BITS - 1:0] ins);
		return ins[9];
	endfunction

	function automatic logic uses_flags_for_branch(input logic [BITS - 1:0] ins);
		return branch_cond_from_ins(ins) == br_z_set || branch_cond_from_ins(ins) == br_z_clear;
	endfunction

	function automatic logic [BITS - 1:0] branch_offset_from_ins(input logic [BITS - 1:0] ins);
		return {{(BITS - OFFSET_BITS){ins[OFFSET_BITS - 1]}}, ins[OFFSET_BITS - 1:0]};
	endfunction

endpackage
